//--- hw/mxu_pkg.sv
`default_nettype none

package mxu_pkg;

    // datapath geometry
    localparam int LANES  = 4;
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 18;
    localparam int RES_W  = 16;

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef elem_t [LANES-1:0] in_word_t;
    typedef logic signed [RES_W-1:0] res_t;
    typedef res_t [LANES-1:0] out_word_t;

    // host write opcode
    typedef enum logic {
        HOST_CSR    = 1'b0,
        HOST_WEIGHT = 1'b1
    } host_target_e;

    // mode: shift in 3:0, relu in bit 4
    typedef enum logic [1:0] {
        CSR_MODE  = 2'd0,
        CSR_COUNT = 2'd1
    } csr_addr_e;

    typedef struct packed {
        logic         strobe;
        host_target_e target;
        logic [1:0]   addr;
        in_word_t     data;
    } host_wr_t;

    typedef struct packed {
        logic [3:0] shift;
        logic       relu;
        logic [7:0] count;
    } csr_cfg_t;

    // one weight row per command
    typedef struct packed {
        logic       valid;
        logic [1:0] row;
        logic       first;
        logic       last;
    } row_cmd_t;

    typedef enum logic [3:0] {
        ST_POWER_UP = 4'h0,
        ST_IDLE     = 4'h1,
        ST_COMPUTE  = 4'h2,
        ST_DONE     = 4'h3,
        ST_RETRIEVE = 4'h4,
        ST_FLUSH    = 4'h7,
        ST_START_P1 = 4'h8,
        ST_START_P2 = 4'h9,
        ST_START_P3 = 4'hA
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/csr_bank.sv
`default_nettype none

module csr_bank (
    input  logic              clk,
    input  logic              reset,
    input  mxu_pkg::host_wr_t host_wr,
    input  logic              clear,
    output mxu_pkg::csr_cfg_t cfg
);

    // registers only take the low byte of the data word
    logic [7:0] wr_byte;
    logic       csr_wr;

    assign wr_byte = host_wr.data[0];
    assign csr_wr  = host_wr.strobe && (host_wr.target == mxu_pkg::HOST_CSR);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            // defaults: no shift, relu off, one vector
            cfg <= '{shift: 4'd0, relu: 1'b0, count: 8'd1};
        end else if (csr_wr) begin
            case (mxu_pkg::csr_addr_e'(host_wr.addr))
                mxu_pkg::CSR_MODE: begin
                    cfg.shift <= wr_byte[3:0];
                    cfg.relu  <= wr_byte[4];
                end
                mxu_pkg::CSR_COUNT: cfg.count <= wr_byte;
                default: ;
            endcase
        end
    end

    a_csr_addr_defined: assert property (@(posedge clk) disable iff (reset)
        csr_wr |-> host_wr.addr inside {mxu_pkg::CSR_MODE, mxu_pkg::CSR_COUNT})
        else $error("csr write to undefined address %0d", host_wr.addr);

endmodule

`default_nettype wire

//--- hw/stream_fifo.sv
`default_nettype none

module stream_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         write,
    input  logic [WIDTH-1:0]             wdata,
    input  logic                         read,
    output logic [WIDTH-1:0]             rdata,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   level
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [LW-1:0]    count;
    logic             do_write;
    logic             do_read;

    // strobes past the flags are dropped, asserts below catch them
    assign do_write = write && !full;
    assign do_read  = read && !empty;

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= wdata;
    end

    // head word falls through
    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == LW'(DEPTH));
    assign level = count;

    a_no_write_full: assert property (@(posedge clk) disable iff (reset) write |-> !full)
        else $error("fifo write while full");
    a_no_read_empty: assert property (@(posedge clk) disable iff (reset) read |-> !empty)
        else $error("fifo read while empty");

endmodule

`default_nettype wire

//--- hw/weight_memory.sv
`default_nettype none

module weight_memory (
    input  logic              clk,
    input  logic              reset,
    input  mxu_pkg::host_wr_t host_wr,
    input  logic              clear,
    input  logic              rd,
    input  logic [1:0]        rd_row,
    output mxu_pkg::in_word_t row_data
);

    // one row per output lane
    mxu_pkg::in_word_t rows [mxu_pkg::LANES];
    logic              wm_wr;

    assign wm_wr = host_wr.strobe && (host_wr.target == mxu_pkg::HOST_WEIGHT);

    // host side, whole row per write
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            for (int i = 0; i < mxu_pkg::LANES; i++)
                rows[i] <= '0;
        end else if (wm_wr) begin
            rows[host_wr.addr] <= host_wr.data;
        end
    end

    // registered read
    // lines up with stage 0 of the mac array
    always_ff @(posedge clk) begin
        if (rd)
            row_data <= rows[rd_row];
    end

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`default_nettype none

module control_unit #(
    parameter int OUT_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             glb_enable,
    input  logic                             cs_start,
    output logic                             cs_ready,
    output logic                             cs_done,
    output logic                             cs_idle,
    input  mxu_pkg::csr_cfg_t                cfg,
    output logic                             mem_clear,
    input  logic                             in_empty,
    output logic                             in_read,
    input  logic [$clog2(OUT_DEPTH+1)-1:0]   out_level,
    input  logic                             word_valid,
    output logic                             wm_read,
    output mxu_pkg::row_cmd_t                cmd
);

    localparam int LW = $clog2(OUT_DEPTH + 1);
    localparam logic [1:0] LAST_ROW = 2'(mxu_pkg::LANES - 1);

    mxu_pkg::ctrl_state_e state;
    logic [1:0]           row_idx;
    logic [7:0]           vec_cnt;
    logic [LW-1:0]        inflight;
    logic [LW-1:0]        free_slots;
    logic                 issue;

    ////////////////////////////////////////////////////////////
    // credits
    assign free_slots = LW'(OUT_DEPTH) - out_level;
    // in_read high means the head pop is still pending, wait a cycle
    assign issue = (state == mxu_pkg::ST_RETRIEVE) && !in_empty && !in_read
                   && (free_slots > inflight);

    // vectors issued but not yet in the output fifo
    always_ff @(posedge clk) begin
        if (reset) begin
            inflight <= '0;
        end else begin
            case ({issue, word_valid})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // job fsm, strobes default low every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= mxu_pkg::ST_POWER_UP;
            cs_ready  <= 1'b0;
            cs_done   <= 1'b0;
            cs_idle   <= 1'b0;
            mem_clear <= 1'b0;
            in_read   <= 1'b0;
            wm_read   <= 1'b0;
            cmd       <= '0;
            row_idx   <= '0;
            vec_cnt   <= '0;
        end else begin
            cs_ready  <= 1'b0;
            cs_done   <= 1'b0;
            cs_idle   <= 1'b0;
            mem_clear <= 1'b0;
            in_read   <= 1'b0;
            wm_read   <= 1'b0;
            cmd       <= '0;
            case (state)
                // wipe config and weights once
                mxu_pkg::ST_POWER_UP: begin
                    mem_clear <= 1'b1;
                    state     <= mxu_pkg::ST_IDLE;
                end
                mxu_pkg::ST_IDLE: begin
                    cs_idle <= 1'b1;
                    if (cs_start && glb_enable)
                        state <= mxu_pkg::ST_START_P1;
                end
                // start must stay up for three cycles
                mxu_pkg::ST_START_P1:
                    state <= cs_start ? mxu_pkg::ST_START_P2 : mxu_pkg::ST_IDLE;
                mxu_pkg::ST_START_P2:
                    state <= cs_start ? mxu_pkg::ST_START_P3 : mxu_pkg::ST_IDLE;
                mxu_pkg::ST_START_P3: begin
                    if (cs_start) begin
                        cs_ready <= 1'b1;
                        vec_cnt  <= '0;
                        state    <= mxu_pkg::ST_RETRIEVE;
                    end else begin
                        state <= mxu_pkg::ST_IDLE;
                    end
                end
                // hold here on back-pressure
                mxu_pkg::ST_RETRIEVE: begin
                    if (issue) begin
                        cmd     <= '{valid: 1'b1, row: 2'd0, first: 1'b1, last: 1'b0};
                        wm_read <= 1'b1;
                        row_idx <= 2'd1;
                        vec_cnt <= vec_cnt + 8'd1;
                        state   <= mxu_pkg::ST_COMPUTE;
                    end
                end
                // remaining rows, pop the head with the last one
                mxu_pkg::ST_COMPUTE: begin
                    cmd <= '{valid: 1'b1, row: row_idx, first: 1'b0,
                             last: (row_idx == LAST_ROW)};
                    wm_read <= 1'b1;
                    if (row_idx == LAST_ROW) begin
                        in_read <= 1'b1;
                        state   <= (vec_cnt == cfg.count) ? mxu_pkg::ST_FLUSH
                                                          : mxu_pkg::ST_RETRIEVE;
                    end else begin
                        row_idx <= row_idx + 2'd1;
                    end
                end
                // drain the pipeline
                mxu_pkg::ST_FLUSH: begin
                    if (inflight == '0)
                        state <= mxu_pkg::ST_DONE;
                end
                mxu_pkg::ST_DONE: begin
                    cs_done <= 1'b1;
                    state   <= mxu_pkg::ST_IDLE;
                end
                default: state <= mxu_pkg::ST_POWER_UP;
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) in_read |-> !in_empty)
        else $error("input fifo popped while empty");

endmodule

`default_nettype wire

//--- hw/mac_row_array.sv
`default_nettype none

module mac_row_array (
    input  logic               clk,
    input  logic               reset,
    input  mxu_pkg::row_cmd_t  cmd,
    input  mxu_pkg::in_word_t  vec,
    input  mxu_pkg::in_word_t  row_data,
    input  mxu_pkg::csr_cfg_t  cfg,
    output logic               word_valid,
    output mxu_pkg::out_word_t word
);

    localparam int AW = mxu_pkg::ACC_W;
    localparam int RW = mxu_pkg::RES_W;
    localparam logic signed [AW-1:0] SAT_MAX = AW'(2 ** (RW - 1) - 1);
    localparam logic signed [AW-1:0] SAT_MIN = -AW'(2 ** (RW - 1));

    mxu_pkg::row_cmd_t     s0_cmd;
    mxu_pkg::row_cmd_t     s1_cmd;
    mxu_pkg::in_word_t     s0_vec;
    logic signed [AW-1:0]  dot;
    logic signed [AW-1:0]  s1_acc;
    logic signed [AW-1:0]  shifted;
    mxu_pkg::res_t         lane_res;

    // command valid bits through the stages
    always_ff @(posedge clk) begin
        if (reset) begin
            s0_cmd     <= '0;
            s1_cmd     <= '0;
            word_valid <= 1'b0;
        end else begin
            s0_cmd     <= cmd;
            s1_cmd     <= s0_cmd;
            word_valid <= s1_cmd.valid && s1_cmd.last;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 0 vector, weight row arrives from memory alongside
    always_ff @(posedge clk) begin
        if (cmd.valid)
            s0_vec <= vec;
    end

    // stage 1 dot product, operands sign extended to acc width
    always_comb begin
        dot = '0;
        for (int i = 0; i < mxu_pkg::LANES; i++)
            dot = dot + s0_vec[i] * row_data[i];
    end

    always_ff @(posedge clk) begin
        if (s0_cmd.valid)
            s1_acc <= dot;
    end

    ////////////////////////////////////////////////////////////
    // stage 2 shift, saturate, relu
    always_comb begin
        shifted = s1_acc >>> cfg.shift;
        if (shifted > SAT_MAX)
            lane_res = SAT_MAX[RW-1:0];
        else if (shifted < SAT_MIN)
            lane_res = SAT_MIN[RW-1:0];
        else
            lane_res = shifted[RW-1:0];
        if (cfg.relu && lane_res[RW-1])
            lane_res = '0;
    end

    // lane placement, a first row starts a fresh word
    always_ff @(posedge clk) begin
        if (s1_cmd.valid) begin
            if (s1_cmd.first)
                word <= '0;
            word[s1_cmd.row] <= lane_res;
        end
    end

    // first and last flags must match the row index
    a_cmd_flags: assert property (@(posedge clk) disable iff (reset)
        cmd.valid |-> (cmd.first == (cmd.row == 2'd0))
                      && (cmd.last == (cmd.row == 2'(mxu_pkg::LANES - 1))))
        else $error("row command flags do not match row index");

endmodule

`default_nettype wire

//--- hw/mxu_top.sv
`default_nettype none

module mxu_top #(
    parameter int IN_DEPTH  = 8,
    parameter int OUT_DEPTH = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               glb_enable,
    input  logic               cs_start,
    output logic               cs_ready,
    output logic               cs_done,
    output logic               cs_idle,
    input  mxu_pkg::host_wr_t  host_wr,
    input  logic               in_write,
    input  mxu_pkg::in_word_t  in_data,
    output logic               in_full,
    input  logic               out_read,
    output mxu_pkg::out_word_t out_data,
    output logic               out_empty
);

    mxu_pkg::csr_cfg_t                  cfg;
    logic                               mem_clear;
    mxu_pkg::in_word_t                  in_head;
    logic                               in_empty;
    logic                               infifo_read;
    logic                               wm_read;
    mxu_pkg::row_cmd_t                  row_cmd;
    mxu_pkg::in_word_t                  row_data;
    logic                               word_valid;
    mxu_pkg::out_word_t                 word;
    logic [$clog2(OUT_DEPTH+1)-1:0]     out_level;

    ////////////////////////////////////////////////////////////
    // input side
    csr_bank u_csr_bank (
        .clk(clk), .reset(reset), .host_wr(host_wr), .clear(mem_clear), .cfg(cfg)
    );

    weight_memory u_weight_memory (
        .clk(clk), .reset(reset), .host_wr(host_wr), .clear(mem_clear),
        .rd(wm_read), .rd_row(row_cmd.row), .row_data(row_data)
    );

    stream_fifo #(.WIDTH($bits(mxu_pkg::in_word_t)), .DEPTH(IN_DEPTH)) u_in_fifo (
        .clk(clk), .reset(reset), .write(in_write), .wdata(in_data),
        .read(infifo_read), .rdata(in_head), .empty(in_empty), .full(in_full), .level()
    );

    ////////////////////////////////////////////////////////////
    // processing
    control_unit #(.OUT_DEPTH(OUT_DEPTH)) u_control_unit (
        .clk(clk), .reset(reset), .glb_enable(glb_enable), .cs_start(cs_start),
        .cs_ready(cs_ready), .cs_done(cs_done), .cs_idle(cs_idle), .cfg(cfg),
        .mem_clear(mem_clear), .in_empty(in_empty), .in_read(infifo_read),
        .out_level(out_level), .word_valid(word_valid), .wm_read(wm_read), .cmd(row_cmd)
    );

    mac_row_array u_mac_row_array (
        .clk(clk), .reset(reset), .cmd(row_cmd), .vec(in_head), .row_data(row_data),
        .cfg(cfg), .word_valid(word_valid), .word(word)
    );

    // output side, credits keep it from overflowing
    stream_fifo #(.WIDTH($bits(mxu_pkg::out_word_t)), .DEPTH(OUT_DEPTH)) u_out_fifo (
        .clk(clk), .reset(reset), .write(word_valid), .wdata(word),
        .read(out_read), .rdata(out_data), .empty(out_empty), .full(), .level(out_level)
    );

endmodule

`default_nettype wire

//--- tests/mxu_tb_model.svh
`ifndef MXU_TB_MODEL_SVH
`define MXU_TB_MODEL_SVH

// copies of what the host wrote
mxu_pkg::elem_t     model_w [mxu_pkg::LANES][mxu_pkg::LANES];
int                 model_shift;
bit                 model_relu;
// expected output words, oldest first
mxu_pkg::out_word_t exp_q [$];

function automatic void model_reset();
    for (int r = 0; r < mxu_pkg::LANES; r++)
        for (int i = 0; i < mxu_pkg::LANES; i++)
            model_w[r][i] = '0;
    model_shift = 0;
    model_relu  = 1'b0;
    exp_q.delete();
endfunction

// mode byte: shift in 3:0, relu in bit 4
function automatic void model_mode(input logic [7:0] mode);
    model_shift = mode[3:0];
    model_relu  = mode[4];
endfunction

function automatic void model_weight(input int row, input mxu_pkg::in_word_t data);
    for (int i = 0; i < mxu_pkg::LANES; i++)
        model_w[row][i] = data[i];
endfunction

// arithmetic shift, clamp to the 16 bit range, optional relu
function automatic int lane_result(input int sum);
    int lim;
    int r;
    lim = 1 << (mxu_pkg::RES_W - 1);
    r = sum >>> model_shift;
    if (r > lim - 1)
        r = lim - 1;
    if (r < -lim)
        r = -lim;
    if (model_relu && r < 0)
        r = 0;
    return r;
endfunction

// one output word per pushed vector, lane n from weight row n
function automatic void model_push(input mxu_pkg::in_word_t vec);
    mxu_pkg::out_word_t w;
    int                 sum;
    for (int r = 0; r < mxu_pkg::LANES; r++) begin
        sum = 0;
        for (int i = 0; i < mxu_pkg::LANES; i++)
            sum += int'(vec[i]) * int'(model_w[r][i]);
        w[r] = 16'(lane_result(sum));
    end
    exp_q.push_back(w);
endfunction

`endif

//--- tests/mxu_tb.sv
`default_nettype none

module mxu_tb;

    localparam int NUM_JOBS = 6;
    localparam int IN_DEPTH = 8;
    // vectors per job and traffic style
    // style 0 random, 1 stalled output with bursty input, 2 slow input
    localparam int JOB_COUNT [NUM_JOBS] = '{1, 4, 12, 20, 9, 30};
    localparam int JOB_STYLE [NUM_JOBS] = '{0, 0, 2, 1, 2, 1};

    logic               clk;
    logic               reset;
    logic               glb_enable;
    logic               cs_start;
    logic               cs_ready;
    logic               cs_done;
    logic               cs_idle;
    mxu_pkg::host_wr_t  host_wr;
    logic               in_write;
    mxu_pkg::in_word_t  in_data;
    logic               in_full;
    logic               out_read;
    mxu_pkg::out_word_t out_data;
    logic               out_empty;
    integer             seed = 32'h6c44ecda;
    int                 words_popped;

    `include "mxu_tb_model.svh"

    mxu_top #(.IN_DEPTH(IN_DEPTH), .OUT_DEPTH(8)) UUT (
        .clk(clk), .reset(reset), .glb_enable(glb_enable), .cs_start(cs_start),
        .cs_ready(cs_ready), .cs_done(cs_done), .cs_idle(cs_idle), .host_wr(host_wr),
        .in_write(in_write), .in_data(in_data), .in_full(in_full),
        .out_read(out_read), .out_data(out_data), .out_empty(out_empty)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // checks
    task automatic end_with_failure();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input mxu_pkg::out_word_t expected,
                              input mxu_pkg::out_word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] out_data expected %h actual %h", expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    // some words all max or all min to push sums into saturation
    function automatic mxu_pkg::in_word_t rand_word();
        mxu_pkg::in_word_t w;
        int                pick;
        pick = $random(seed) & 7;
        for (int i = 0; i < mxu_pkg::LANES; i++)
            w[i] = (pick == 0) ? 8'h7f : (pick == 1) ? 8'h80 : 8'($random(seed));
        return w;
    endfunction

    task automatic host_write(input mxu_pkg::host_target_e target, input logic [1:0] addr,
                              input mxu_pkg::in_word_t data);
        @(negedge clk);
        host_wr = '{strobe: 1'b1, target: target, addr: addr, data: data};
        @(negedge clk);
        host_wr = '0;
    endtask

    // mode, count and all weight rows, mirrored into the model
    task automatic configure_job(input int count, input bit no_shift);
        logic [7:0]        mode;
        mxu_pkg::in_word_t row;
        check_flag("cs_idle", cs_idle, 1'b1);
        mode = 8'($random(seed)) & 8'h1f;
        if (no_shift)
            mode[3:0] = 4'd0;
        host_write(mxu_pkg::HOST_CSR, mxu_pkg::CSR_MODE, 32'(mode));
        model_mode(mode);
        host_write(mxu_pkg::HOST_CSR, mxu_pkg::CSR_COUNT, 32'(count));
        for (int r = 0; r < mxu_pkg::LANES; r++) begin
            row = rand_word();
            host_write(mxu_pkg::HOST_WEIGHT, 2'(r), row);
            model_weight(r, row);
        end
    endtask

    // head word is stable at the falling edge, popped at the next rising one
    task automatic pop_step(input bit want);
        out_read = 1'b0;
        if (want && !out_empty) begin
            if (exp_q.size() == 0) begin
                $display("output word appeared with no vector pending");
                end_with_failure();
            end
            check_word(exp_q.pop_front(), out_data);
            out_read = 1'b1;
            words_popped++;
        end
    endtask

    // start dropped in start_p2, then start held with the block disabled
    // input fifo stays full from the queued vectors
    task automatic check_start_rejected();
        @(negedge clk);
        cs_start = 1'b1;
        repeat (2) @(negedge clk);
        cs_start = 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_flag("cs_ready", cs_ready, 1'b0);
            check_flag("out_empty", out_empty, 1'b1);
            check_flag("in_full", in_full, 1'b1);
        end
        check_flag("cs_idle", cs_idle, 1'b1);
        glb_enable = 1'b0;
        cs_start   = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_flag("cs_ready", cs_ready, 1'b0);
            check_flag("cs_idle", cs_idle, 1'b1);
            check_flag("out_empty", out_empty, 1'b1);
            check_flag("in_full", in_full, 1'b1);
        end
        cs_start   = 1'b0;
        glb_enable = 1'b1;
    endtask

    task automatic run_job(input int count, input int style, input int pushed0);
        int pushed;
        int popped0;
        int cyc;
        int readies;
        int dones;
        bit want_push;
        bit want_pop;
        pushed  = pushed0;
        popped0 = words_popped;
        cyc     = 0;
        readies = 0;
        dones   = 0;
        @(negedge clk);
        cs_start = 1'b1;
        while (dones == 0) begin
            @(negedge clk);
            cyc++;
            if (cs_ready) begin
                readies++;
                cs_start = 1'b0;
            end
            if (cs_done) begin
                dones++;
                // every word of the job is in the output fifo or already popped
                check_flag("out_empty", out_empty, (words_popped - popped0) == count);
            end else if (readies > 0) begin
                check_flag("cs_idle", cs_idle, 1'b0);
            end
            case (style)
                1: begin
                    // 8 cycle input bursts, output stalled for a while
                    want_push = ((cyc / 8) % 2) == 0;
                    want_pop  = (cyc > 60) && ($random(seed) & 1);
                end
                2: begin
                    want_push = ($random(seed) & 3) == 0;
                    want_pop  = 1'b1;
                end
                default: begin
                    want_push = ($random(seed) & 3) != 0;
                    want_pop  = ($random(seed) & 3) != 0;
                end
            endcase
            pop_step(want_pop);
            in_write = 1'b0;
            if (want_push && !in_full && pushed < count) begin
                in_data  = rand_word();
                in_write = 1'b1;
                model_push(in_data);
                pushed++;
            end
        end
        in_write = 1'b0;
        // everything left sits in the output fifo
        do begin
            @(negedge clk);
            if (cs_ready)
                readies++;
            if (cs_done)
                dones++;
            pop_step(1'b1);
        end while (!out_empty);
        repeat (3) begin
            @(negedge clk);
            check_flag("cs_ready", cs_ready, 1'b0);
            check_flag("cs_done", cs_done, 1'b0);
        end
        check_count("words per job", words_popped - popped0, count);
        check_count("cs_ready pulses", readies, 1);
        check_count("cs_done pulses", dones, 1);
        check_count("pending expected words", exp_q.size(), 0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        int pre;
        clk          = 1'b0;
        reset        = 1'b1;
        glb_enable   = 1'b1;
        cs_start     = 1'b0;
        host_wr      = '0;
        in_write     = 1'b0;
        in_data      = '0;
        out_read     = 1'b0;
        words_popped = 0;
        model_reset();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        // power up clears, then idle
        for (int n = 0; n < 10 && !cs_idle; n++) begin
            @(negedge clk);
            check_flag("cs_ready", cs_ready, 1'b0);
            check_flag("cs_done", cs_done, 1'b0);
            check_flag("out_empty", out_empty, 1'b1);
        end
        if (!cs_idle) begin
            $display("cs_idle never rose after reset");
            end_with_failure();
        end
        for (int j = 0; j < NUM_JOBS; j++) begin
            configure_job(JOB_COUNT[j], (j % 2) == 0);
            pre = 0;
            if (j == 2) begin
                // fill the input fifo, queued vectors must survive rejected starts
                for (int k = 0; k < IN_DEPTH; k++) begin
                    @(negedge clk);
                    check_flag("in_full", in_full, 1'b0);
                    in_data  = rand_word();
                    in_write = 1'b1;
                    model_push(in_data);
                end
                @(negedge clk);
                in_write = 1'b0;
                check_flag("in_full", in_full, 1'b1);
                check_start_rejected();
                pre = IN_DEPTH;
            end
            run_job(JOB_COUNT[j], JOB_STYLE[j], pre);
        end
        $display("TEST PASS");
        $finish;
    end

    // watchdog, budget per job with margin for stalls
    initial begin
        int limit;
        limit = 100;
        for (int j = 0; j < NUM_JOBS; j++)
            limit += 2 * (JOB_COUNT[j] * 4 + 40);
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress", limit);
        end_with_failure();
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+tests
hw/mxu_pkg.sv
hw/csr_bank.sv
hw/stream_fifo.sv
hw/weight_memory.sv
hw/control_unit.sv
hw/mac_row_array.sv
hw/mxu_top.sv
tests/mxu_tb.sv

//--- Bender.yml
package:
  name: mxu_accel

sources:
  - files:
      - hw/mxu_pkg.sv
      - hw/csr_bank.sv
      - hw/stream_fifo.sv
      - hw/weight_memory.sv
      - hw/control_unit.sv
      - hw/mac_row_array.sv
      - hw/mxu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/mxu_tb.sv
